// File: design/hps_pkg.sv
// shared constants for the host command link
// bus and register widths, host command codes,
// PS/2 clock divider and transmit FIFO size

package hps_pkg;

	// bus and register widths
	localparam int HOST_W   = 16;
	localparam int JOY_W    = 32;
	localparam int STATUS_W = 64;
	localparam int CFG_W    = 16;
	localparam int ADDR_W   = 27;
	localparam int BYTE_W   = 8;

	// word counter within one command, saturates at all ones
	localparam int CNT_W = 4;

	// PS/2 clock toggles every PS2_DIV+1 system clocks
	localparam int PS2_DIV = 4;

	// transmit FIFO holds 2**PS2_FIFO_BITS bytes
	localparam int PS2_FIFO_BITS = 4;

	//////////////////////////////////////////////////////////////////////
	// host command codes
	//////////////////////////////////////////////////////////////////////

	localparam logic [HOST_W-1:0] CMD_CFG        = 16'h0001;
	localparam logic [HOST_W-1:0] CMD_JOY0       = 16'h0002;
	localparam logic [HOST_W-1:0] CMD_JOY1       = 16'h0003;
	localparam logic [HOST_W-1:0] CMD_KBD        = 16'h0005;
	localparam logic [HOST_W-1:0] CMD_STATUS     = 16'h001e;
	localparam logic [HOST_W-1:0] CMD_STATUS_REQ = 16'h0029;

	// download commands
	localparam logic [HOST_W-1:0] CMD_FILE_TX   = 16'h0053;
	localparam logic [HOST_W-1:0] CMD_FILE_DAT  = 16'h0054;
	localparam logic [HOST_W-1:0] CMD_FILE_IDX  = 16'h0055;
	localparam logic [HOST_W-1:0] CMD_FILE_INFO = 16'h0056;

	// high nibble of the status request reply
	localparam logic [3:0] STFLAG_TAG = 4'hA;

endpackage

// File: design/hps_cmd_core.sv
// host command core
// word counter and command latch, config/status/joystick registers,
// status request capture and readback, keyboard byte stream

`timescale 1ns/1ps

module hps_cmd_core (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  logic                           io_enable,
	input  logic                           io_strobe,
	input  logic [hps_pkg::HOST_W-1:0]     io_din,
	input  logic [hps_pkg::STATUS_W-1:0]   status_in,
	input  logic                           status_set,
	output logic [hps_pkg::HOST_W-1:0]     io_dout,
	output logic [1:0]                     buttons,
	output logic                           forced_scandoubler,
	output logic                           direct_video,
	output logic [hps_pkg::STATUS_W-1:0]   status,
	output logic [hps_pkg::JOY_W-1:0]      joystick_0,
	output logic [hps_pkg::JOY_W-1:0]      joystick_1,
	output logic [hps_pkg::BYTE_W-1:0]     kbd_byte,
	output logic                           kbd_byte_valid,
	output logic                           kbd_end
);

	import hps_pkg::*;

	logic [HOST_W-1:0]   cmd;
	logic [CNT_W-1:0]    byte_cnt;
	logic [CFG_W-1:0]    cfg;
	logic                ps2skip;

	// status request capture
	logic                old_status_set;
	logic [3:0]          stflg;
	logic [STATUS_W-1:0] status_req;

	// 16-bit slot of the 64-bit words, data words 1 to 4
	logic [1:0]          wsel;
	logic                in_quad;

	assign wsel    = byte_cnt[1:0] - 2'd1;
	assign in_quad = (byte_cnt <= CNT_W'(4));

	// config bits
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];
	assign direct_video       = cfg[10];

	// keyboard data words, skip markers and anything after them are dropped
	assign kbd_byte       = io_din[BYTE_W-1:0];
	assign kbd_byte_valid = io_enable && io_strobe && (cmd == CMD_KBD) &&
	                        !(&io_din[HOST_W-1:BYTE_W]) && !ps2skip;
	// cmd still holds the keyboard code in the cycle io_enable drops
	assign kbd_end        = !io_enable && (cmd == CMD_KBD);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cmd            <= '0;
			byte_cnt       <= '0;
			cfg            <= '0;
			status         <= '0;
			joystick_0     <= '0;
			joystick_1     <= '0;
			ps2skip        <= 1'b0;
			old_status_set <= 1'b0;
			stflg          <= '0;
			status_req     <= '0;
			io_dout        <= '0;
		end else begin
			old_status_set <= status_set;
			if (status_set && !old_status_set) begin
				stflg      <= stflg + 1'd1;
				status_req <= status_in;
			end

			if (!io_enable) begin
				cmd      <= '0;
				byte_cnt <= '0;
				ps2skip  <= 1'b0;
			end else if (io_strobe) begin
				io_dout <= '0;
				if (!(&byte_cnt)) begin
					byte_cnt <= byte_cnt + 1'd1;
				end

				if (byte_cnt == '0) begin
					cmd <= io_din;
					if (io_din == CMD_STATUS_REQ) begin
						io_dout <= {{(HOST_W-8){1'b0}}, STFLAG_TAG, stflg};
					end
				end else begin
					case (cmd)
						CMD_CFG: cfg <= io_din;

						// low half first
						CMD_JOY0: begin
							if (byte_cnt == CNT_W'(1)) begin
								joystick_0[HOST_W-1:0] <= io_din;
							end else begin
								joystick_0[JOY_W-1:HOST_W] <= io_din;
							end
						end
						CMD_JOY1: begin
							if (byte_cnt == CNT_W'(1)) begin
								joystick_1[HOST_W-1:0] <= io_din;
							end else begin
								joystick_1[JOY_W-1:HOST_W] <= io_din;
							end
						end

						// lowest word first, nothing past the fourth
						CMD_STATUS: begin
							if (in_quad) begin
								status[{wsel, 4'b0000} +: HOST_W] <= io_din;
							end
						end

						CMD_STATUS_REQ: begin
							if (in_quad) begin
								io_dout <= status_req[{wsel, 4'b0000} +: HOST_W];
							end
						end

						// high byte all ones marks the rest of the command as skipped
						CMD_KBD: begin
							if (&io_din[HOST_W-1:BYTE_W]) begin
								ps2skip <= 1'b1;
							end
						end

						default: ;
					endcase
				end
			end
		end
	end

	a_ctrl_known: assert property (@(posedge clk_sys) disable iff (reset)
		!$isunknown({stflg, byte_cnt}));

endmodule

// File: design/ps2_key_decoder.sv
// keyboard scan byte collector
// turns each keyboard command into one key event and
// forwards every byte to the PS/2 port

`timescale 1ns/1ps

module ps2_key_decoder (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  logic [hps_pkg::BYTE_W-1:0]   kbd_byte,
	input  logic                         kbd_byte_valid,
	input  logic                         kbd_end,
	output logic [10:0]                  ps2_key,
	output logic [hps_pkg::BYTE_W-1:0]   ps2_wdata,
	output logic                         ps2_we
);

	import hps_pkg::*;

	// last four bytes, newest in the low byte
	logic [4*BYTE_W-1:0] key_raw;
	logic                pressed;
	logic                extended;
	logic [9:0]          key_low;

	// break code F0 sits just before the final byte
	assign pressed  = (key_raw[15:8] != 8'hf0);
	assign extended = pressed ? (key_raw[15:8] == 8'he0) : (key_raw[23:16] == 8'he0);

	always_comb begin
		key_low = {pressed, extended, key_raw[BYTE_W-1:0]};
		case (key_raw)
			// print screen press and release
			32'he012e07c: key_low = 10'h37c;
			32'h7ce0f012: key_low = 10'h17c;
			// pause press
			32'hf014f077: key_low = 10'h377;
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			key_raw   <= '0;
			ps2_key   <= '0;
			ps2_wdata <= '0;
			ps2_we    <= 1'b0;
		end else begin
			ps2_we <= kbd_byte_valid;
			if (kbd_byte_valid) begin
				key_raw   <= {key_raw[3*BYTE_W-1:0], kbd_byte};
				ps2_wdata <= kbd_byte;
			end
			if (kbd_end) begin
				ps2_key <= {~ps2_key[10], key_low};
				// next command starts from an empty collector
				key_raw <= '0;
			end
		end
	end

endmodule

// File: design/file_loader.sv
// file download engine
// file info, index, start/stop and data commands
// drive the byte-wide ioctl write port

`timescale 1ns/1ps

module file_loader (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  logic                           io_enable,
	input  logic                           io_strobe,
	input  logic [hps_pkg::HOST_W-1:0]     io_din,
	input  logic                           ioctl_wait,
	output logic                           ioctl_download,
	output logic [hps_pkg::BYTE_W-1:0]     ioctl_index,
	output logic                           ioctl_wr,
	output logic [hps_pkg::ADDR_W-1:0]     ioctl_addr,
	output logic [hps_pkg::BYTE_W-1:0]     ioctl_dout,
	output logic [2*hps_pkg::HOST_W-1:0]   ioctl_file_ext
);

	import hps_pkg::*;

	logic [HOST_W-1:0] cmd;
	logic              has_cmd;
	logic [1:0]        cnt;
	logic [ADDR_W-1:0] addr;
	logic              wr;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cmd            <= '0;
			has_cmd        <= 1'b0;
			cnt            <= '0;
			addr           <= '0;
			wr             <= 1'b0;
			ioctl_wr       <= 1'b0;
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_addr     <= '0;
			ioctl_dout     <= '0;
			ioctl_file_ext <= '0;
		end else begin
			// write pulse lands one clock after the data is latched
			ioctl_wr <= wr;
			wr       <= 1'b0;

			if (!io_enable) begin
				has_cmd <= 1'b0;
			end else if (io_strobe) begin
				if (!has_cmd) begin
					cmd     <= io_din;
					has_cmd <= 1'b1;
					cnt     <= '0;
				end else begin
					case (cmd)
						// extension, high word first
						CMD_FILE_INFO: begin
							if (!cnt[1]) begin
								if (cnt == 2'd0) begin
									ioctl_file_ext[2*HOST_W-1:HOST_W] <= io_din;
								end else begin
									ioctl_file_ext[HOST_W-1:0] <= io_din;
								end
								cnt <= cnt + 2'd1;
							end
						end

						CMD_FILE_IDX: ioctl_index <= io_din[BYTE_W-1:0];

						// nonzero starts, zero stops and shows the byte count
						CMD_FILE_TX: begin
							if (io_din[BYTE_W-1:0] != '0) begin
								addr           <= '0;
								ioctl_download <= 1'b1;
							end else begin
								ioctl_addr     <= addr;
								ioctl_download <= 1'b0;
							end
						end

						CMD_FILE_DAT: begin
							ioctl_addr <= addr;
							ioctl_dout <= io_din[BYTE_W-1:0];
							wr         <= 1'b1;
							addr       <= addr + 1'd1;
						end

						default: ;
					endcase
				end
			end
		end
	end

	// host honours back-pressure from the core
	a_no_strobe_in_wait: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wait |-> !io_strobe);

	a_wr_single: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wr |=> !ioctl_wr);

endmodule

// File: design/ps2_port.sv
// emulated PS/2 keyboard port
// clock divider, transmit FIFO and
// serial frame transmitter (start, 8 data, odd parity, stop)

`timescale 1ns/1ps

module ps2_port (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  logic [hps_pkg::BYTE_W-1:0]   ps2_wdata,
	input  logic                         ps2_we,
	output logic                         ps2_kbd_clk_out,
	output logic                         ps2_kbd_data_out
);

	import hps_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// clock divider
	//////////////////////////////////////////////////////////////////////

	logic [$clog2(PS2_DIV+1)-1:0] div_cnt;
	logic                         clk_ps2;
	logic                         old_clk;
	logic                         ps2_rise;
	logic                         ps2_fall;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			div_cnt <= '0;
			clk_ps2 <= 1'b0;
			old_clk <= 1'b0;
		end else begin
			old_clk <= clk_ps2;
			if (div_cnt == PS2_DIV) begin
				div_cnt <= '0;
				clk_ps2 <= ~clk_ps2;
			end else begin
				div_cnt <= div_cnt + 1'd1;
			end
		end
	end

	assign ps2_rise = clk_ps2 && !old_clk;
	assign ps2_fall = !clk_ps2 && old_clk;

	//////////////////////////////////////////////////////////////////////
	// transmit FIFO
	//////////////////////////////////////////////////////////////////////

	// pointers carry one extra wrap bit
	logic [BYTE_W-1:0]      fifo [2**PS2_FIFO_BITS];
	logic [PS2_FIFO_BITS:0] wptr;
	logic [PS2_FIFO_BITS:0] rptr;
	logic                   fifo_empty;
	logic                   fifo_full;

	assign fifo_empty = (wptr == rptr);
	assign fifo_full  = (wptr[PS2_FIFO_BITS] != rptr[PS2_FIFO_BITS]) &&
	                    (wptr[PS2_FIFO_BITS-1:0] == rptr[PS2_FIFO_BITS-1:0]);

	always_ff @(posedge clk_sys) begin
		if (ps2_we) begin
			fifo[wptr[PS2_FIFO_BITS-1:0]] <= ps2_wdata;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// frame transmitter
	//////////////////////////////////////////////////////////////////////

	// 0 idle, 1 start, 2..9 data, 10 parity, 11 stop
	logic [3:0]        tx_state;
	logic [BYTE_W-1:0] tx_byte;
	logic              parity;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			wptr             <= '0;
			rptr             <= '0;
			tx_state         <= '0;
			tx_byte          <= '0;
			parity           <= 1'b1;
			ps2_kbd_clk_out  <= 1'b1;
			ps2_kbd_data_out <= 1'b1;
		end else begin
			if (ps2_we) begin
				wptr <= wptr + 1'd1;
			end

			if (ps2_rise) begin
				ps2_kbd_clk_out <= 1'b1;
				if (tx_state == 4'd0) begin
					if (!fifo_empty) begin
						tx_byte          <= fifo[rptr[PS2_FIFO_BITS-1:0]];
						rptr             <= rptr + 1'd1;
						parity           <= 1'b1;
						tx_state         <= 4'd1;
						ps2_kbd_data_out <= 1'b0;
					end
				end else begin
					// data bits go out LSB first
					if (tx_state < 4'd9) begin
						ps2_kbd_data_out <= tx_byte[0];
						tx_byte          <= {1'b0, tx_byte[BYTE_W-1:1]};
						if (tx_byte[0]) begin
							parity <= !parity;
						end
					end
					if (tx_state == 4'd9) begin
						ps2_kbd_data_out <= parity;
					end
					if (tx_state == 4'd10) begin
						ps2_kbd_data_out <= 1'b1;
					end
					tx_state <= (tx_state == 4'd11) ? 4'd0 : tx_state + 4'd1;
				end
			end

			// clock line only pulses low while a frame is in flight
			if (ps2_fall) begin
				ps2_kbd_clk_out <= (tx_state == 4'd0);
			end
		end
	end

	a_no_fifo_overflow: assert property (@(posedge clk_sys) disable iff (reset)
		ps2_we |-> !fifo_full);

endmodule

// File: design/hps_link.sv
// host command link, top level
// command core, key decoder, file loader and PS/2 keyboard port

`timescale 1ns/1ps

module hps_link (
	input  logic                                clk_sys,
	input  logic                                reset,

	// host bus
	input  logic                                io_enable,
	input  logic                                io_strobe,
	input  logic [hps_pkg::HOST_W-1:0]          io_din,
	output logic [hps_pkg::HOST_W-1:0]          io_dout,
	output logic                                io_wait,

	// core-side state
	input  logic [hps_pkg::STATUS_W-1:0]        status_in,
	input  logic                                status_set,
	output logic [1:0]                          buttons,
	output logic                                forced_scandoubler,
	output logic                                direct_video,
	output logic [hps_pkg::STATUS_W-1:0]        status,
	output logic [hps_pkg::JOY_W-1:0]           joystick_0,
	output logic [hps_pkg::JOY_W-1:0]           joystick_1,
	output logic [10:0]                         ps2_key,

	// download port
	input  logic                                ioctl_wait,
	output logic                                ioctl_download,
	output logic [hps_pkg::BYTE_W-1:0]          ioctl_index,
	output logic                                ioctl_wr,
	output logic [hps_pkg::ADDR_W-1:0]          ioctl_addr,
	output logic [hps_pkg::BYTE_W-1:0]          ioctl_dout,
	output logic [2*hps_pkg::HOST_W-1:0]        ioctl_file_ext,

	// emulated keyboard lines
	output logic                                ps2_kbd_clk_out,
	output logic                                ps2_kbd_data_out
);

	import hps_pkg::*;

	// keyboard bytes from the command core
	logic [BYTE_W-1:0] kbd_byte;
	logic              kbd_byte_valid;
	logic              kbd_end;

	// bytes queued for the PS/2 port
	logic [BYTE_W-1:0] ps2_wdata;
	logic              ps2_we;

	// host back-pressure comes straight from the core
	assign io_wait = ioctl_wait;

	hps_cmd_core u_cmd_core (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.io_enable          (io_enable),
		.io_strobe          (io_strobe),
		.io_din             (io_din),
		.status_in          (status_in),
		.status_set         (status_set),
		.io_dout            (io_dout),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.status             (status),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.kbd_byte           (kbd_byte),
		.kbd_byte_valid     (kbd_byte_valid),
		.kbd_end            (kbd_end)
	);

	ps2_key_decoder u_key_decoder (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.kbd_byte       (kbd_byte),
		.kbd_byte_valid (kbd_byte_valid),
		.kbd_end        (kbd_end),
		.ps2_key        (ps2_key),
		.ps2_wdata      (ps2_wdata),
		.ps2_we         (ps2_we)
	);

	file_loader u_file_loader (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.io_enable      (io_enable),
		.io_strobe      (io_strobe),
		.io_din         (io_din),
		.ioctl_wait     (ioctl_wait),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_file_ext (ioctl_file_ext)
	);

	ps2_port u_ps2_port (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.ps2_wdata        (ps2_wdata),
		.ps2_we           (ps2_we),
		.ps2_kbd_clk_out  (ps2_kbd_clk_out),
		.ps2_kbd_data_out (ps2_kbd_data_out)
	);

endmodule

// File: dv/hps_checker.sv
// testbench checker for the host command link
// reference model of config, status, joystick and key registers,
// download write tracking and PS/2 frame decoding

`timescale 1ns/1ps

module hps_checker (
	input  logic                                clk_sys,
	input  logic                                reset,
	input  logic                                io_enable,
	input  logic                                io_strobe,
	input  logic [hps_pkg::HOST_W-1:0]          io_din,
	input  logic [hps_pkg::HOST_W-1:0]          exp_reply,
	input  logic                                done,
	input  logic                                ioctl_wait,
	input  logic [hps_pkg::HOST_W-1:0]          io_dout,
	input  logic                                io_wait,
	input  logic [1:0]                          buttons,
	input  logic                                forced_scandoubler,
	input  logic                                direct_video,
	input  logic [hps_pkg::STATUS_W-1:0]        status,
	input  logic [hps_pkg::JOY_W-1:0]           joystick_0,
	input  logic [hps_pkg::JOY_W-1:0]           joystick_1,
	input  logic [10:0]                         ps2_key,
	input  logic                                ioctl_download,
	input  logic [hps_pkg::BYTE_W-1:0]          ioctl_index,
	input  logic                                ioctl_wr,
	input  logic [hps_pkg::ADDR_W-1:0]          ioctl_addr,
	input  logic [hps_pkg::BYTE_W-1:0]          ioctl_dout,
	input  logic [2*hps_pkg::HOST_W-1:0]        ioctl_file_ext,
	input  logic                                ps2_kbd_clk_out,
	input  logic                                ps2_kbd_data_out,
	output int                                  errors,
	output int                                  checks,
	output logic                                idle
);

	import hps_pkg::*;

	logic [HOST_W-1:0]        cmd;
	int                       cnt;
	logic                     skip;
	logic                     strobe_seen;
	logic [HOST_W-1:0]        reply_q;
	logic [CFG_W-1:0]         exp_cfg;
	logic [STATUS_W-1:0]      exp_status;
	logic [JOY_W-1:0]         exp_joy0;
	logic [JOY_W-1:0]         exp_joy1;
	logic [10:0]              exp_key;
	logic                     exp_dl;
	logic [BYTE_W-1:0]        exp_index;
	logic [2*HOST_W-1:0]      exp_ext;
	logic [ADDR_W-1:0]        dl_addr;
	logic                     addr_chk;
	logic [BYTE_W-1:0]        kq [$];
	logic [BYTE_W-1:0]        ps2_q [$];
	logic [ADDR_W+BYTE_W-1:0] wr_q [$];

	// PS/2 frame decoder state
	logic                     prev_clk;
	int                       bit_cnt;
	logic [10:0]              frame;

	task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	// pressed unless F0 before the last byte, extended when E0 precedes the code
	task automatic form_key_event();
		logic [7:0] last;
		logic [7:0] b1;
		logic [7:0] b2;
		logic       pressed;
		logic       ext;
		int         n;
		n       = kq.size();
		last    = (n >= 1) ? kq[n-1] : 8'h00;
		b1      = (n >= 2) ? kq[n-2] : 8'h00;
		b2      = (n >= 3) ? kq[n-3] : 8'h00;
		pressed = (b1 != 8'hf0);
		ext     = pressed ? (b1 == 8'he0) : (b2 == 8'he0);
		exp_key = {~exp_key[10], pressed, ext, last};
		kq.delete();
	endtask

	task automatic apply_word();
		case (cmd)
			CMD_CFG: exp_cfg = io_din;
			CMD_JOY0: begin
				if (cnt == 1) exp_joy0[15:0] = io_din;
				else exp_joy0[31:16] = io_din;
			end
			CMD_JOY1: begin
				if (cnt == 1) exp_joy1[15:0] = io_din;
				else exp_joy1[31:16] = io_din;
			end
			CMD_STATUS: begin
				if (cnt <= 4) exp_status[(cnt-1)*16 +: 16] = io_din;
			end
			CMD_KBD: begin
				if (&io_din[15:8]) begin
					skip = 1'b1;
				end else if (!skip) begin
					kq.push_back(io_din[7:0]);
					ps2_q.push_back(io_din[7:0]);
				end
			end
			CMD_FILE_IDX: exp_index = io_din[7:0];
			CMD_FILE_INFO: begin
				if (cnt == 1) exp_ext[31:16] = io_din;
				else if (cnt == 2) exp_ext[15:0] = io_din;
			end
			CMD_FILE_TX: begin
				if (io_din[7:0] != 8'h00) begin
					exp_dl   = 1'b1;
					dl_addr  = '0;
					addr_chk = 1'b0;
				end else begin
					exp_dl   = 1'b0;
					addr_chk = 1'b1;
				end
			end
			CMD_FILE_DAT: begin
				wr_q.push_back({dl_addr, io_din[7:0]});
				dl_addr  = dl_addr + 1'b1;
				addr_chk = 1'b0;
			end
			default: ;
		endcase
	endtask

	// model follows the host bus on the rising edge
	always @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cmd         = '0;
			cnt         = 0;
			skip        = 1'b0;
			strobe_seen = 1'b0;
			reply_q     = '0;
			exp_cfg     = '0;
			exp_status  = '0;
			exp_joy0    = '0;
			exp_joy1    = '0;
			exp_key     = '0;
			exp_dl      = 1'b0;
			exp_index   = '0;
			exp_ext     = '0;
			dl_addr     = '0;
			addr_chk    = 1'b0;
		end else begin
			// back-pressure passes straight through to the host
			check_val("io_wait", ioctl_wait, io_wait);
			strobe_seen = io_enable && io_strobe;
			if (strobe_seen) reply_q = exp_reply;
			if (!io_enable) begin
				if (cmd == CMD_KBD) form_key_event();
				cmd  = '0;
				cnt  = 0;
				skip = 1'b0;
			end else if (io_strobe) begin
				if (cnt == 0) cmd = io_din;
				else apply_word();
				if (cnt < 15) cnt++;
			end
		end
	end

	task automatic check_frame();
		if (frame[0] !== 1'b0) begin
			errors++;
			$display("PS/2 frame at %0t has no start bit", $time);
		end
		if (^frame[9:1] !== 1'b1) begin
			errors++;
			$display("PS/2 frame at %0t has wrong parity", $time);
		end
		if (frame[10] !== 1'b1) begin
			errors++;
			$display("PS/2 frame at %0t has no stop bit", $time);
		end
		if (ps2_q.size() == 0) begin
			errors++;
			$display("PS/2 frame at %0t was never queued", $time);
		end else begin
			check_val("ps2_byte", ps2_q.pop_front(), frame[8:1]);
		end
	endtask

	// outputs are compared on the falling edge, half a cycle after they move
	always @(negedge clk_sys) begin
		logic [ADDR_W+BYTE_W-1:0] w;
		if (!reset) begin
			check_val("buttons", exp_cfg[1:0], buttons);
			check_val("forced_scandoubler", exp_cfg[4], forced_scandoubler);
			check_val("direct_video", exp_cfg[10], direct_video);
			check_val("status", exp_status, status);
			check_val("joystick_0", exp_joy0, joystick_0);
			check_val("joystick_1", exp_joy1, joystick_1);
			check_val("ps2_key", exp_key, ps2_key);
			check_val("ioctl_download", exp_dl, ioctl_download);
			check_val("ioctl_index", exp_index, ioctl_index);
			check_val("ioctl_file_ext", exp_ext, ioctl_file_ext);
			if (strobe_seen) check_val("io_dout", reply_q, io_dout);
			if (addr_chk) check_val("ioctl_addr", dl_addr, ioctl_addr);
			if (ioctl_wr) begin
				if (wr_q.size() == 0) begin
					errors++;
					$display("ioctl_wr pulsed at %0t with no data word sent", $time);
				end else begin
					w = wr_q.pop_front();
					check_val("ioctl_addr", w[ADDR_W+BYTE_W-1:BYTE_W], ioctl_addr);
					check_val("ioctl_dout", w[BYTE_W-1:0], ioctl_dout);
				end
			end
			if (prev_clk && !ps2_kbd_clk_out) begin
				frame[bit_cnt] = ps2_kbd_data_out;
				bit_cnt++;
				if (bit_cnt == 11) begin
					check_frame();
					bit_cnt = 0;
				end
			end
		end
		prev_clk = ps2_kbd_clk_out;
		idle     = (ps2_q.size() == 0) && (wr_q.size() == 0) && (bit_cnt == 0);
	end

	always @(posedge done) begin
		if (wr_q.size() != 0) begin
			errors++;
			$display("%0d download bytes were never written", wr_q.size());
		end
		if (ps2_q.size() != 0) begin
			errors++;
			$display("%0d keyboard bytes never left the PS/2 port", ps2_q.size());
		end
	end

	initial begin
		errors   = 0;
		checks   = 0;
		idle     = 1'b0;
		prev_clk = 1'b1;
		bit_cnt  = 0;
		frame    = '0;
	end

endmodule

// File: dv/tb_hps_link.sv
// testbench top for the host command link
// clock and reset, host bus driver, stimulus table,
// cycle limit and closing report

`timescale 1ns/1ps

module tb_hps_link;

	import hps_pkg::*;

	localparam int ROWS      = 14;
	localparam int FIRST_DL  = 8;
	localparam int KBD_BYTES = 6;

	logic                  clk_sys;
	logic                  reset;
	logic                  io_enable;
	logic                  io_strobe;
	logic [HOST_W-1:0]     io_din;
	logic [STATUS_W-1:0]   status_in;
	logic                  status_set;
	logic                  ioctl_wait;
	logic [HOST_W-1:0]     exp_reply;
	logic                  done;
	logic [HOST_W-1:0]     io_dout;
	logic                  io_wait;
	logic [1:0]            buttons;
	logic                  forced_scandoubler;
	logic                  direct_video;
	logic [STATUS_W-1:0]   status;
	logic [JOY_W-1:0]      joystick_0;
	logic [JOY_W-1:0]      joystick_1;
	logic [10:0]           ps2_key;
	logic                  ioctl_download;
	logic [BYTE_W-1:0]     ioctl_index;
	logic                  ioctl_wr;
	logic [ADDR_W-1:0]     ioctl_addr;
	logic [BYTE_W-1:0]     ioctl_dout;
	logic [2*HOST_W-1:0]   ioctl_file_ext;
	logic                  ps2_kbd_clk_out;
	logic                  ps2_kbd_data_out;
	int                    errors;
	int                    checks;
	logic                  idle;

	// stimulus table: command, data word count, data words, replies
	logic [HOST_W-1:0]     tbl_cmd [ROWS];
	int                    tbl_n   [ROWS];
	logic [63:0]           tbl_dat [ROWS];
	logic [79:0]           tbl_rep [ROWS];
	int                    seed;
	int                    cycles;
	int                    limit;

	hps_link DUT (.*);

	hps_checker u_checker (.*);

	always #20 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles++;
		if (limit > 0 && cycles >= limit) begin
			$display("run stopped after %0d cycles without finishing", cycles);
			$display("Regression failed");
			$finish;
		end
	end

	task automatic set_row(input int r, input logic [15:0] c, input int n, input logic [63:0] w);
		tbl_cmd[r] = c;
		tbl_n[r]   = n;
		tbl_dat[r] = w;
		tbl_rep[r] = '0;
	endtask

	task automatic pulse_status(input logic [63:0] value);
		@(negedge clk_sys);
		status_in  = value;
		status_set = 1'b1;
		@(negedge clk_sys);
		status_set = 1'b0;
	endtask

	// one host transaction, strobes held off while io_wait is high
	task automatic run_row(input int r);
		@(negedge clk_sys);
		io_enable = 1'b1;
		for (int i = 0; i <= tbl_n[r]; i++) begin
			if (r >= FIRST_DL) begin
				ioctl_wait = $random(seed) & 1;
				while (io_wait) begin
					@(negedge clk_sys);
					ioctl_wait = $random(seed) & 1;
				end
			end
			io_din    = (i == 0) ? tbl_cmd[r] : tbl_dat[r][63-16*(i-1) -: 16];
			exp_reply = tbl_rep[r][79-16*i -: 16];
			io_strobe = 1'b1;
			@(negedge clk_sys);
			io_strobe = 1'b0;
			@(negedge clk_sys);
		end
		ioctl_wait = 1'b0;
		io_enable  = 1'b0;
		@(negedge clk_sys);
		@(negedge clk_sys);
	endtask

	initial begin
		clk_sys    = 1'b0;
		reset      = 1'b1;
		io_enable  = 1'b0;
		io_strobe  = 1'b0;
		io_din     = '0;
		status_in  = '0;
		status_set = 1'b0;
		ioctl_wait = 1'b0;
		exp_reply  = '0;
		done       = 1'b0;
		seed       = 32'h45f2_2913;
		cycles     = 0;
		limit      = 0;

		set_row(0, CMD_CFG, 1, 64'h0413_0000_0000_0000);
		set_row(1, CMD_STATUS, 4, 64'h1111_2222_3333_4444);
		set_row(2, CMD_JOY0, 2, 64'ha5a5_5a5a_0000_0000);
		set_row(3, CMD_JOY1, 2, 64'h0f0f_f0f0_0000_0000);
		set_row(4, CMD_STATUS_REQ, 4, 64'h0);
		// tag A with two captured requests, then the last status_in lowest word first
		tbl_rep[4] = 80'h00a2_cdef_89ab_4567_0123;
		set_row(5, CMD_KBD, 1, 64'h001c_0000_0000_0000);
		set_row(6, CMD_KBD, 2, 64'h00f0_001c_0000_0000);
		set_row(7, CMD_KBD, 3, 64'h00e0_00f0_0075_0000);
		set_row(8, CMD_FILE_IDX, 1, 64'h0003_0000_0000_0000);
		set_row(9, CMD_FILE_INFO, 2, 64'h4249_4e00_0000_0000);
		set_row(10, CMD_FILE_TX, 1, 64'h0001_0000_0000_0000);
		set_row(11, CMD_FILE_DAT, 4, 64'h0012_0034_0056_0078);
		set_row(12, CMD_FILE_DAT, 4, 64'h009a_00bc_00de_00f1);
		set_row(13, CMD_FILE_TX, 1, 64'h0000_0000_0000_0000);

		// random waits can at most double each strobe slot
		limit = 200;
		for (int r = 0; r < ROWS; r++) begin
			limit += 4 * (2 * (tbl_n[r] + 1) + 2);
		end
		limit += 12 * 11 * 2 * (PS2_DIV + 1) * KBD_BYTES;

		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;

		pulse_status(64'h5555_6666_7777_8888);
		pulse_status(64'h0123_4567_89ab_cdef);

		for (int r = 0; r < ROWS; r++) begin
			run_row(r);
		end

		// let the PS/2 frames drain
		@(posedge clk_sys);
		while (!idle) @(posedge clk_sys);
		@(negedge clk_sys);
		done = 1'b1;
		repeat (2) @(negedge clk_sys);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// File: flist.f
design/hps_pkg.sv
design/hps_cmd_core.sv
design/ps2_key_decoder.sv
design/file_loader.sv
design/ps2_port.sv
design/hps_link.sv
dv/hps_checker.sv
dv/tb_hps_link.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the host link testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f flist.f --top-module tb_hps_link \
	--Mdir obj_dir -o sim_hps_link > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/sim_hps_link > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see sim.log"
	exit 1
fi

if grep -qx "Regression passed" sim.log; then
	echo "PASS"
	exit 0
else
	echo "FAIL, see sim.log"
	exit 1
fi
